// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_pu_array
RTL_TOP    ?= pu_array
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no verdict in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== nn_pkg.sv ====
package nn_pkg;

	localparam int op_width   = 16;
	localparam int num_pe     = 4;
	localparam int word_width = op_width * num_pe;  // one buffer word holds a full lane vector
	localparam int acc_width  = 40;
	localparam int id_width   = 10;

	typedef logic signed [op_width-1:0]  op_t;
	typedef logic signed [acc_width-1:0] acc_t;

	// bias sits in the low lane of the word
	typedef struct packed {
		logic [word_width-op_width-1:0] unused;
		op_t                            bias;
	} bias_view_t;

	// a buffer word is either a bias or one weight per lane
	typedef union packed {
		bias_view_t              b;
		op_t [num_pe-1:0]        weights;  // lane 0 in the low bits
	} buf_word_u;

	// broadcast read stream
	typedef struct packed {
		buf_word_u               word;
		logic [id_width-1:0]     id;
		logic                    valid;
	} rd_beat_t;

	// input vector, one operand per lane
	typedef struct packed {
		op_t [num_pe-1:0]        ops;
		logic                    last;  // closes the layer
	} vec_t;

endpackage

// ==== pe.sv ====
`timescale 1ns/1ns

module pe
(
	input  logic         clk,
	input  logic         reset,
	input  logic         en,
	input  logic         clear,
	input  nn_pkg::op_t  op,
	input  nn_pkg::op_t  weight,
	output nn_pkg::acc_t acc
);

	logic signed [2*nn_pkg::op_width-1:0] prod;

	// product stage, free running
	always_ff @(posedge clk)
	begin
		prod <= op * weight;
	end

	// accumulate stage, wraps at acc_width
	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (clear)
		begin
			// start over, keeping a product that lands on the same edge
			if (en)
				acc <= nn_pkg::acc_t'(prod);
			else
				acc <= '0;
		end
		else if (en)
			acc <= acc + nn_pkg::acc_t'(prod);
	end

endmodule

// ==== pu.sv ====
`timescale 1ns/1ns

module pu
#(
	parameter int PU_ID         = 0,
	parameter int WR_ADDR_WIDTH = 5
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic             layer_start,
	input  nn_pkg::rd_beat_t rd,
	output logic             accepted,
	input  nn_pkg::vec_t     vec,
	input  logic             vec_fire,
	output logic             ready,
	output nn_pkg::acc_t     result,
	output logic             valid,
	input  logic             take
);

	localparam logic [nn_pkg::id_width-1:0] pu_id_bits = PU_ID[nn_pkg::id_width-1:0];

	logic match;
	logic bias_load;
	logic wr_en;
	logic bias_v;
	nn_pkg::op_t bias;

	nn_pkg::buf_word_u rd_word;
	nn_pkg::op_t [nn_pkg::num_pe-1:0] s1_ops;
	logic s1_valid, s1_last;
	logic s2_valid, s2_last;
	logic s3_last;
	logic pending;

	nn_pkg::acc_t acc [nn_pkg::num_pe];
	nn_pkg::acc_t lane_sum;

	assign match     = rd.valid && rd.id == pu_id_bits;
	assign bias_load = match && !bias_v;  // first word of the layer
	assign wr_en     = match && bias_v;
	assign accepted  = bias_load || wr_en;

	always_ff @(posedge clk)
	begin
		if (reset || layer_start)
			bias_v <= 1'b0;
		else if (bias_load)
			bias_v <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (bias_load)
			bias <= rd.word.b.bias;
	end

	weight_buffer #(
		.WR_ADDR_WIDTH (WR_ADDR_WIDTH)
	) wb (
		.clk         (clk),
		.reset       (reset),
		.layer_start (layer_start),
		.wr_en       (wr_en),
		.wr_word     (rd.word),
		.rd_en       (vec_fire),
		.rd_restart  (vec.last),
		.rd_word     (rd_word)
	);

	// s1 lines up with rd_word, s2 with the product register, s3 with the accumulators
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
			s2_valid <= 1'b0;
			s2_last  <= 1'b0;
			s3_last  <= 1'b0;
		end
		else
		begin
			s1_valid <= vec_fire;
			s1_last  <= vec_fire && vec.last;
			s2_valid <= s1_valid;
			s2_last  <= s1_last;
			s3_last  <= s2_last;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_ops <= vec.ops;
	end

	for (genvar i = 0; i < nn_pkg::num_pe; i++)
	begin : g_pe
		pe lane (
			.clk    (clk),
			.reset  (reset),
			.en     (s2_valid),
			.clear  (s3_last),  // cleared by the result load
			.op     (s1_ops[i]),
			.weight (rd_word.weights[i]),
			.acc    (acc[i])
		);
	end

	always_comb
	begin
		lane_sum = nn_pkg::acc_t'(bias);  // sign extended
		for (int i = 0; i < nn_pkg::num_pe; i++)
			lane_sum = lane_sum + acc[i];
	end

	always_ff @(posedge clk)
	begin
		if (s3_last)
			result <= lane_sum;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= 1'b0;
		else if (s3_last)
			valid <= 1'b1;
		else if (take)
			valid <= 1'b0;
	end

	// no new vectors until this layer's result has left
	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= 1'b0;
		else if (vec_fire && vec.last)
			pending <= 1'b1;
		else if (take)
			pending <= 1'b0;
	end

	assign ready = !pending;

endmodule

// ==== pu_array.sv ====
`timescale 1ns/1ns

module pu_array
#(
	parameter int NUM_PU        = 4,
	parameter int WR_ADDR_WIDTH = 5
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      layer_start,
	input  nn_pkg::rd_beat_t          rd,
	output logic                      read_req,
	input  nn_pkg::vec_t              vec,
	input  logic                      vec_valid,
	output logic                      vec_ready,
	output nn_pkg::acc_t [NUM_PU-1:0] result,
	output logic                      result_valid,
	input  logic                      result_ready
);

	typedef nn_pkg::acc_t [NUM_PU-1:0] result_t;

	result_t pu_result;

	logic [NUM_PU-1:0] pu_accepted;
	logic [NUM_PU-1:0] pu_ready;
	logic [NUM_PU-1:0] pu_valid;

	logic vec_fire;
	logic take;

	// all units move together on both streams
	assign read_req     = |pu_accepted;
	assign vec_ready    = &pu_ready;
	assign vec_fire     = vec_valid && vec_ready;
	assign result_valid = &pu_valid;
	assign take         = result_valid && result_ready;
	assign result       = pu_result;

	for (genvar i = 0; i < NUM_PU; i++)
	begin : g_pu
		pu #(
			.PU_ID         (i),
			.WR_ADDR_WIDTH (WR_ADDR_WIDTH)
		) unit (
			.clk         (clk),
			.reset       (reset),
			.layer_start (layer_start),
			.rd          (rd),           // broadcast, each unit filters on its id
			.accepted    (pu_accepted[i]),
			.vec         (vec),
			.vec_fire    (vec_fire),
			.ready       (pu_ready[i]),
			.result      (pu_result[i]),
			.valid       (pu_valid[i]),
			.take        (take)
		);
	end

endmodule

// ==== pu_array_props.sv ====
`timescale 1ns/1ns

module pu_array_props
#(
	parameter int NUM_PU = 4
)
(
	input logic                      clk,
	input logic                      reset,
	input nn_pkg::rd_beat_t          rd,
	input logic                      read_req,
	input nn_pkg::vec_t              vec,
	input logic                      vec_valid,
	input logic                      vec_ready,
	input nn_pkg::acc_t [NUM_PU-1:0] result,
	input logic                      result_valid,
	input logic                      result_ready
);

	// producer holds its vector through a stall
	a_vec_held: assert property (@(posedge clk) disable iff (reset)
		vec_valid && !vec_ready |=> vec_valid && $stable(vec))
		else $error("vec dropped or changed while stalled");

	a_result_held: assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("result dropped or changed while stalled");

	// read_req flags exactly the valid beats that some unit owns
	a_req_matches_id: assert property (@(posedge clk) disable iff (reset)
		read_req == (rd.valid && rd.id < NUM_PU))
		else $error("read_req does not match the id of the read beat");

endmodule

// ==== sources.f ====
nn_pkg.sv
pe.sv
weight_buffer.sv
pu.sv
pu_array.sv
pu_array_props.sv
tb_pu_array.sv

// ==== tb_pu_array.sv ====
`timescale 1ns/1ns

module tb_pu_array;

	localparam int NUM_PU        = 4;
	localparam int WR_ADDR_WIDTH = 5;

	typedef struct {
		string name;
		int    nvec;
		int    bubble_pct;  // chance of a gap in vec_valid
		int    stall_pct;   // chance of result_ready low
		int    stray_pct;   // chance of a beat for no unit
	} test_t;

	test_t tests [6] = '{
		'{"single_vector", 1, 0, 0, 0},
		'{"stray_ids", 4, 0, 0, 40},
		'{"bubbles", 16, 40, 0, 10},
		'{"full_depth", 32, 20, 0, 10},
		'{"result_stalls", 8, 10, 70, 10},
		'{"back_to_back", 32, 50, 50, 25}
	};

	logic clk;
	logic reset;
	logic layer_start;
	nn_pkg::rd_beat_t rd;
	logic read_req;
	nn_pkg::vec_t vec;
	logic vec_valid;
	logic vec_ready;
	nn_pkg::acc_t [NUM_PU-1:0] result;
	logic result_valid;
	logic result_ready;

	// reference model state
	nn_pkg::op_t  bias_m [NUM_PU];
	logic [63:0]  wts [NUM_PU][32];
	nn_pkg::acc_t exp_res [NUM_PU];
	nn_pkg::acc_t prev_res [NUM_PU];  // expected results of the layer being collected

	pu_array #(
		.NUM_PU        (NUM_PU),
		.WR_ADDR_WIDTH (WR_ADDR_WIDTH)
	) uut (
		.clk          (clk),
		.reset        (reset),
		.layer_start  (layer_start),
		.rd           (rd),
		.read_req     (read_req),
		.vec          (vec),
		.vec_valid    (vec_valid),
		.vec_ready    (vec_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

	bind pu_array pu_array_props #(.NUM_PU(NUM_PU)) props (
		.clk          (clk),
		.reset        (reset),
		.rd           (rd),
		.read_req     (read_req),
		.vec          (vec),
		.vec_valid    (vec_valid),
		.vec_ready    (vec_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// bias then weights per unit in shuffled order with strays mixed in
	task automatic load_layer(input test_t t);
		int order [$];
		int cnt [NUM_PU];
		int j, k, u, tmp;
		logic stray;
		logic [63:0] w;
		nn_pkg::rd_beat_t beat;
		for (u = 0; u < NUM_PU; u++)
		begin
			cnt[u] = 0;
			for (j = 0; j <= t.nvec; j++)
				order.push_back(u);
		end
		for (j = order.size() - 1; j > 0; j--)
		begin
			k = $urandom_range(j);
			tmp = order[j];
			order[j] = order[k];
			order[k] = tmp;
		end
		@(posedge clk);
		layer_start <= 1'b1;
		@(posedge clk);
		layer_start <= 1'b0;
		j = 0;
		while (j < order.size())
		begin
			w = {$urandom, $urandom};
			stray = $urandom_range(99) < t.stray_pct;
			beat.word  = w;
			beat.valid = 1'b1;
			if (stray)
				beat.id = 10'(NUM_PU + $urandom_range(1023 - NUM_PU));
			else
			begin
				u = order[j];
				j++;
				beat.id = 10'(u);
				if (cnt[u] == 0)
					bias_m[u] = w[15:0];  // first word of a unit is its bias
				else
					wts[u][cnt[u]-1] = w;
				cnt[u]++;
			end
			rd <= beat;
			@(negedge clk);
			check($sformatf("%s read_req", t.name), 64'(!stray), 64'(read_req));
			@(posedge clk);
		end
		rd <= '0;
	endtask

	task automatic stream_vectors(input test_t t);
		int v, u, l;
		logic presenting;
		nn_pkg::vec_t cur;
		nn_pkg::op_t wl;
		for (u = 0; u < NUM_PU; u++)
			exp_res[u] = nn_pkg::acc_t'(bias_m[u]);
		v = 0;
		presenting = 1'b0;
		while (v < t.nvec)
		begin
			@(posedge clk);
			if (!presenting && $urandom_range(99) >= t.bubble_pct)
			begin
				for (l = 0; l < nn_pkg::num_pe; l++)
					cur.ops[l] = nn_pkg::op_t'($urandom);
				cur.last = (v == t.nvec - 1);
				vec <= cur;
				presenting = 1'b1;
			end
			vec_valid <= presenting;
			@(negedge clk);
			if (presenting && vec_ready)
			begin
				for (u = 0; u < NUM_PU; u++)
					for (l = 0; l < nn_pkg::num_pe; l++)
					begin
						wl = wts[u][v][16*l +: 16];
						exp_res[u] = exp_res[u] + nn_pkg::acc_t'(cur.ops[l]) * nn_pkg::acc_t'(wl);
					end
				v++;
				presenting = 1'b0;
			end
		end
		@(posedge clk);
		vec_valid <= 1'b0;
	endtask

	task automatic collect_result(input test_t t);
		int u;
		logic got;
		got = 1'b0;
		while (!got)
		begin
			@(posedge clk);
			result_ready <= $urandom_range(99) >= t.stall_pct;
			@(negedge clk);
			if (result_valid && result_ready)
			begin
				got = 1'b1;
				for (u = 0; u < NUM_PU; u++)
					check($sformatf("%s pu%0d", t.name, u), 64'(prev_res[u]), 64'(result[u]));
			end
			else
				check($sformatf("%s vec_ready held", t.name), 64'(0), 64'(vec_ready));
		end
		@(posedge clk);
		result_ready <= 1'b0;
		@(negedge clk);
		check($sformatf("%s result taken once", t.name), 64'(0), 64'(result_valid));
		check($sformatf("%s vec_ready back", t.name), 64'(1), 64'(vec_ready));
	endtask

	// watchdog allows 200 cycles per vector over all tests plus a margin
	initial
	begin
		int total;
		total = 0;
		foreach (tests[i])
			total += tests[i].nvec;
		repeat (total * 200 + 1000) @(posedge clk);
		$display("timeout: the run made no progress and was stopped as hung");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		void'($urandom(32'hc765_ff18));
		reset        = 1'b1;
		layer_start  = 1'b0;
		rd           = '0;
		vec          = '0;
		vec_valid    = 1'b0;
		result_ready = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("reset result_valid", 64'(0), 64'(result_valid));
		check("reset read_req", 64'(0), 64'(read_req));
		check("reset vec_ready", 64'(1), 64'(vec_ready));
		foreach (tests[i])
		begin
			// the previous result is loaded and no longer needs the old bias
			if (i > 0)
				wait (result_valid);
			load_layer(tests[i]);
			prev_res = exp_res;
			// new vectors wait on the previous result while it is collected
			fork
				if (i > 0)
					collect_result(tests[i-1]);
				stream_vectors(tests[i]);
			join
		end
		prev_res = exp_res;
		collect_result(tests[$size(tests)-1]);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== weight_buffer.sv ====
`timescale 1ns/1ns

module weight_buffer
#(
	parameter int WR_ADDR_WIDTH = 5
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              layer_start,
	input  logic              wr_en,
	input  nn_pkg::buf_word_u wr_word,
	input  logic              rd_en,
	input  logic              rd_restart,
	output nn_pkg::buf_word_u rd_word
);

	localparam int depth = 2 ** WR_ADDR_WIDTH;

	nn_pkg::buf_word_u mem [depth];

	logic [WR_ADDR_WIDTH-1:0] wr_ptr;
	logic [WR_ADDR_WIDTH-1:0] rd_ptr;

	always_ff @(posedge clk)
	begin
		if (reset || layer_start)
			wr_ptr <= '0;
		else if (wr_en && wr_ptr != {WR_ADDR_WIDTH{1'b1}})
			wr_ptr <= wr_ptr + 1'b1;  // sticks at the last entry
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_word;
	end

	// one word per accepted vector, back to the top after the last one
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_ptr <= '0;
		else if (rd_en)
			rd_ptr <= rd_restart ? '0 : rd_ptr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_word <= mem[rd_ptr];
	end

endmodule
